// ==== source/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Byte address into the memory behind the cache
`define CACHE_ADDR_W 17

// Data word carried on both the processor and the memory side
`define CACHE_WORD_W 32

// Sets per way and the index that selects one of them
`define CACHE_INDEX_W 8
`define CACHE_SETS 256

// Tag is what remains after byte offset, word select and index
`define CACHE_TAG_W 6

// Two ways since the LRU encoding only works for a pair
`define CACHE_WAYS 2

`endif

// ==== source/cache_pkg.sv ====
package cache_pkg;

    `include "cache_defs.svh"

    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    typedef logic [`CACHE_WORD_W-1:0] word_t;

    // High word above low word with address bit 2 selecting between them
    typedef logic [2*`CACHE_WORD_W-1:0] line_t;

    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_WAYS-1:0] way_vec_t;

    typedef enum logic [3:0] {
        st_sweep,
        st_idle,
        st_lookup,
        st_check,
        st_fetch_first,
        st_gap,
        st_fetch_second,
        st_write_line,
        st_respond
    } ctrl_state_t;

endpackage

// ==== source/cache_way.sv ====
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_way (
    input  logic              clk,
    input  cache_pkg::index_t index,
    input  cache_pkg::tag_t   lookup_tag,
    input  logic              wr_en,
    input  cache_pkg::line_t  wr_line,
    input  cache_pkg::tag_t   wr_tag,
    input  logic              wr_valid,
    input  logic              wr_lru,
    output logic              hit,
    output cache_pkg::line_t  rd_line,
    output logic              rd_lru
);

    import cache_pkg::*;

    ////////////////////////////////////////////////////////////
    // Per-set storage
    ////////////////////////////////////////////////////////////

    line_t data_mem [`CACHE_SETS];
    tag_t  tag_mem [`CACHE_SETS];
    logic  valid_mem [`CACHE_SETS];
    logic  lru_mem [`CACHE_SETS];

    tag_t rd_tag;
    logic rd_valid;

    // Whole entry is rewritten on every write including LRU updates
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[index] <= wr_line;
            tag_mem[index] <= wr_tag;
            valid_mem[index] <= wr_valid;
            lru_mem[index] <= wr_lru;
        end
    end

    // Registered read returns the old contents when the same set is written
    always_ff @(posedge clk) begin
        rd_line <= data_mem[index];
        rd_tag <= tag_mem[index];
        rd_valid <= valid_mem[index];
        rd_lru <= lru_mem[index];
    end

    ////////////////////////////////////////////////////////////
    // Tag compare
    ////////////////////////////////////////////////////////////

    // Lookup tag is held steady by the controller across the read
    assign hit = rd_valid && (rd_tag == lookup_tag);

endmodule

// ==== source/way_select.sv ====
`timescale 1ns/1ps

`include "cache_defs.svh"

module way_select (
    input  cache_pkg::way_vec_t hits,
    input  cache_pkg::line_t    lines [`CACHE_WAYS],
    input  cache_pkg::way_vec_t lru_bits,
    output logic                hit,
    output logic                hit_way,
    output cache_pkg::line_t    hit_line,
    output logic                victim_way
);

    import cache_pkg::*;

    ////////////////////////////////////////////////////////////
    // Hit reduction
    ////////////////////////////////////////////////////////////

    // Lowest set bit wins, so way 0 is preferred on a double hit
    way_vec_t first_hit;

    assign first_hit = hits & (~hits + way_vec_t'(1));

    assign hit = |hits;

    // Way number of the winning hit or 0 when nothing hit
    assign hit_way = first_hit[1];

    assign hit_line = lines[hit_way];

    ////////////////////////////////////////////////////////////
    // Replacement choice
    ////////////////////////////////////////////////////////////

    // Equal LRU bits mark way 0 as the more recent and unequal bits mark way 1
    // The victim is the other way
    always_comb begin
        if (lru_bits[0] == lru_bits[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = 1'b0;
        end
    end

endmodule

// ==== source/cache_ctrl.sv ====
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::addr_t    sys_addr,
    input  logic                sys_valid,
    output logic                sys_ready,
    output cache_pkg::word_t    sys_rdata,
    output cache_pkg::addr_t    mem_addr,
    output logic                mem_valid,
    input  logic                mem_ready,
    input  cache_pkg::word_t    mem_rdata,
    output cache_pkg::index_t   index,
    output cache_pkg::tag_t     lookup_tag,
    output cache_pkg::way_vec_t wr_en,
    output cache_pkg::line_t    wr_line,
    output cache_pkg::tag_t     wr_tag,
    output logic                wr_valid,
    output cache_pkg::way_vec_t wr_lru,
    input  logic                hit,
    input  logic                hit_way,
    input  cache_pkg::line_t    hit_line,
    input  logic                victim_way,
    input  cache_pkg::way_vec_t lru_bits
);

    import cache_pkg::*;

    ctrl_state_t state;
    index_t      sweep_cnt;
    addr_t       addr_q;
    line_t       line_q;

    // Word of a line picked by address bit 2
    function automatic word_t pick_word(line_t line, logic sel);
        return sel ? line[2*`CACHE_WORD_W-1:`CACHE_WORD_W] : line[`CACHE_WORD_W-1:0];
    endfunction

    // Line with one of its words replaced
    function automatic line_t place_word(line_t line, word_t word, logic sel);
        line_t result;
        result = line;
        if (sel) begin
            result[2*`CACHE_WORD_W-1:`CACHE_WORD_W] = word;
        end else begin
            result[`CACHE_WORD_W-1:0] = word;
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_sweep;
            sweep_cnt <= '0;
            sys_ready <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            case (state)
                st_sweep: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == index_t'(`CACHE_SETS - 1)) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    if (sys_valid) begin
                        state <= st_lookup;
                    end
                end
                // Way read of the latched index is in flight
                st_lookup: state <= st_check;
                st_check: begin
                    if (hit) begin
                        sys_ready <= 1'b1;
                        state <= st_respond;
                    end else if (!mem_ready) begin
                        // Previous memory handshake must be fully closed
                        mem_valid <= 1'b1;
                        state <= st_fetch_first;
                    end
                end
                st_fetch_first: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        state <= st_gap;
                    end
                end
                st_gap: begin
                    if (!mem_ready) begin
                        mem_valid <= 1'b1;
                        state <= st_fetch_second;
                    end
                end
                st_fetch_second: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        state <= st_write_line;
                    end
                end
                st_write_line: begin
                    sys_ready <= 1'b1;
                    state <= st_respond;
                end
                st_respond: begin
                    // Ready is held until the processor lets go
                    if (!sys_valid) begin
                        sys_ready <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Request address, fill line and read data
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (sys_valid) begin
                    addr_q <= sys_addr;
                end
            end
            st_check: begin
                if (hit) begin
                    sys_rdata <= pick_word(hit_line, addr_q[2]);
                end else begin
                    // Requested word goes out first
                    mem_addr <= {addr_q[`CACHE_ADDR_W-1:3], addr_q[2], 2'b00};
                end
            end
            st_fetch_first: begin
                if (mem_ready) begin
                    line_q <= place_word(line_q, mem_rdata, addr_q[2]);
                end
            end
            st_gap: mem_addr <= {addr_q[`CACHE_ADDR_W-1:3], ~addr_q[2], 2'b00};
            st_fetch_second: begin
                if (mem_ready) begin
                    line_q <= place_word(line_q, mem_rdata, ~addr_q[2]);
                end
            end
            st_write_line: sys_rdata <= pick_word(line_q, addr_q[2]);
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Way port drive
    ////////////////////////////////////////////////////////////

    assign lookup_tag = addr_q[`CACHE_ADDR_W-1:`CACHE_ADDR_W-`CACHE_TAG_W];

    always_comb begin
        index = addr_q[`CACHE_INDEX_W+2:3];
        wr_en = '0;
        wr_line = line_q;
        wr_tag = lookup_tag;
        wr_valid = 1'b1;
        // Way 0 copies way 1, way 1 takes the inverse of way 0
        wr_lru = {~lru_bits[0], lru_bits[1]};
        case (state)
            st_sweep: begin
                index = sweep_cnt;
                wr_en = '1;
                wr_line = '0;
                wr_tag = '0;
                wr_valid = 1'b0;
                wr_lru = '0;
            end
            st_check: begin
                // Hit rewrites its own entry with a fresh LRU bit
                if (hit) begin
                    wr_en = way_vec_t'(1) << hit_way;
                end
                wr_line = hit_line;
            end
            st_write_line: wr_en = way_vec_t'(1) << victim_way;
            default: ;
        endcase
    end

endmodule

// ==== source/cache_top.sv ====
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_top (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t sys_addr,
    input  logic             sys_valid,
    output logic             sys_ready,
    output cache_pkg::word_t sys_rdata,
    output cache_pkg::addr_t mem_addr,
    output logic             mem_valid,
    input  logic             mem_ready,
    input  cache_pkg::word_t mem_rdata
);

    import cache_pkg::*;

    // Shared way inputs from the controller
    index_t   index;
    tag_t     lookup_tag;
    way_vec_t wr_en;
    line_t    wr_line;
    tag_t     wr_tag;
    logic     wr_valid;
    way_vec_t wr_lru;

    // Per-way results
    way_vec_t hits;
    line_t    lines [`CACHE_WAYS];
    way_vec_t lru_bits;

    // Selector outputs back to the controller
    logic  hit;
    logic  hit_way;
    line_t hit_line;
    logic  victim_way;

    ////////////////////////////////////////////////////////////
    // Controller
    ////////////////////////////////////////////////////////////

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .sys_addr   (sys_addr),
        .sys_valid  (sys_valid),
        .sys_ready  (sys_ready),
        .sys_rdata  (sys_rdata),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .index      (index),
        .lookup_tag (lookup_tag),
        .wr_en      (wr_en),
        .wr_line    (wr_line),
        .wr_tag     (wr_tag),
        .wr_valid   (wr_valid),
        .wr_lru     (wr_lru),
        .hit        (hit),
        .hit_way    (hit_way),
        .hit_line   (hit_line),
        .victim_way (victim_way),
        .lru_bits   (lru_bits)
    );

    ////////////////////////////////////////////////////////////
    // Ways and selector
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
        cache_way u_way (
            .clk        (clk),
            .index      (index),
            .lookup_tag (lookup_tag),
            .wr_en      (wr_en[g]),
            .wr_line    (wr_line),
            .wr_tag     (wr_tag),
            .wr_valid   (wr_valid),
            .wr_lru     (wr_lru[g]),
            .hit        (hits[g]),
            .rd_line    (lines[g]),
            .rd_lru     (lru_bits[g])
        );
    end

    way_select u_sel (
        .hits       (hits),
        .lines      (lines),
        .lru_bits   (lru_bits),
        .hit        (hit),
        .hit_way    (hit_way),
        .hit_line   (hit_line),
        .victim_way (victim_way)
    );

endmodule

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps

`include "cache_defs.svh"

module cache_tb;

    import cache_pkg::*;

    localparam int READ_TIMEOUT = 1000;
    localparam int RANDOM_READS = 300;
    localparam int IMAGE_WORDS = 2**(`CACHE_ADDR_W-2);

    logic  clk;
    logic  rst;
    addr_t sys_addr;
    logic  sys_valid;
    logic  sys_ready;
    word_t sys_rdata;
    addr_t mem_addr;
    logic  mem_valid;
    logic  mem_ready;
    word_t mem_rdata;

    integer seed = 32'h99ce;

    word_t image [IMAGE_WORDS];
    addr_t mem_log [$];
    logic  resp_busy;
    int    resp_delay;

    // Reference model of the two-way sets
    tag_t model_tag [`CACHE_WAYS][`CACHE_SETS];
    logic model_valid [`CACHE_WAYS][`CACHE_SETS];
    logic model_mru [`CACHE_SETS];

    logic seen_hit;
    int   rnd;
    tag_t lru_tags [6];
    logic lru_expect [6];

    cache_top dut (
        .clk       (clk),
        .rst       (rst),
        .sys_addr  (sys_addr),
        .sys_valid (sys_valid),
        .sys_ready (sys_ready),
        .sys_rdata (sys_rdata),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic stop_on_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic addr_t make_addr(input tag_t tag, input index_t idx, input logic word_sel);
        return {tag, idx, word_sel, 2'b00};
    endfunction

    // Returns the predicted hit and updates the model as the cache should
    function automatic logic model_access(input addr_t addr);
        index_t idx;
        tag_t   tag;
        logic   victim;
        idx = addr[`CACHE_INDEX_W+2:3];
        tag = addr[`CACHE_ADDR_W-1:`CACHE_ADDR_W-`CACHE_TAG_W];
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == tag) begin
                model_mru[idx] = w[0];
                return 1'b1;
            end
        end
        victim = ~model_mru[idx];
        model_valid[victim][idx] = 1'b1;
        model_tag[victim][idx] = tag;
        model_mru[idx] = victim;
        return 1'b0;
    endfunction

    ////////////////////////////////////////////////////////////
    // Memory responder
    ////////////////////////////////////////////////////////////

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        resp_busy = 1'b0;
        resp_delay = 0;
        forever begin
            @(negedge clk);
            if (rst) begin
                mem_ready = 1'b0;
                resp_busy = 1'b0;
            end else if (mem_ready) begin
                // Close the handshake once the cache has taken the word
                if (!mem_valid) begin
                    mem_ready = 1'b0;
                end
            end else if (mem_valid) begin
                if (!resp_busy) begin
                    resp_busy = 1'b1;
                    resp_delay = $unsigned($random(seed)) % 6;
                end
                if (resp_delay == 0) begin
                    mem_rdata = image[mem_addr[`CACHE_ADDR_W-1:2]];
                    mem_ready = 1'b1;
                    resp_busy = 1'b0;
                    mem_log.push_back(mem_addr);
                end else begin
                    resp_delay = resp_delay - 1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Handshake properties
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) rst |=> (!sys_ready && !mem_valid))
        else stop_on_error("sys_ready or mem_valid was high after reset");

    assert property (@(posedge clk) disable iff (rst) $rose(mem_valid) |-> $past(!mem_ready))
        else stop_on_error("mem_valid rose while mem_ready was still high");

    assert property (@(posedge clk) disable iff (rst) (sys_ready && sys_valid) |=> sys_ready)
        else stop_on_error("sys_ready fell while sys_valid was still held");

    assert property (@(posedge clk) disable iff (rst) (sys_ready && !sys_valid) |=> !sys_ready)
        else stop_on_error("sys_ready stayed high after sys_valid fell");

    // One four-phase read on the processor side checked against the model
    task automatic read_word(input addr_t addr, output logic hit_seen);
        logic  predicted_hit;
        word_t expected;
        addr_t first_addr;
        addr_t second_addr;
        int    waited;
        int    hold;
        predicted_hit = model_access(addr);
        expected = image[addr[`CACHE_ADDR_W-1:2]];
        first_addr = {addr[`CACHE_ADDR_W-1:2], 2'b00};
        second_addr = {addr[`CACHE_ADDR_W-1:3], ~addr[2], 2'b00};
        mem_log.delete();
        sys_addr = addr;
        sys_valid = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > READ_TIMEOUT) begin
                stop_on_error($sformatf("timeout waiting for sys_ready on read of %h", addr));
            end
        end while (!sys_ready);
        hit_seen = (mem_log.size() == 0);
        assert (sys_rdata == expected)
            else stop_on_mismatch($sformatf("read %h returned %h, expected %h",
                                            addr, sys_rdata, expected));
        assert (hit_seen == predicted_hit)
            else stop_on_mismatch($sformatf("read %h saw %0d memory requests, model hit %0b",
                                            addr, mem_log.size(), predicted_hit));
        if (predicted_hit) begin
            // Valid is sampled at the first rising edge and ready comes two edges later
            assert (waited == 3)
                else stop_on_mismatch($sformatf("hit on %h answered %0d edges after sampling",
                                                addr, waited - 1));
        end else begin
            assert (mem_log.size() == 2)
                else stop_on_mismatch($sformatf("miss on %h made %0d memory requests",
                                                addr, mem_log.size()));
            assert (mem_log[0] == first_addr && mem_log[1] == second_addr)
                else stop_on_mismatch($sformatf("miss on %h fetched %h then %h",
                                                addr, mem_log[0], mem_log[1]));
        end
        hold = $unsigned($random(seed)) % 5;
        repeat (hold) begin
            @(negedge clk);
            assert (sys_ready && sys_rdata == expected)
                else stop_on_error("sys_ready or sys_rdata changed while sys_valid was held");
        end
        sys_valid = 1'b0;
        @(negedge clk);
        assert (!sys_ready)
            else stop_on_error("sys_ready did not fall one cycle after sys_valid fell");
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        rst = 1'b1;
        sys_addr = '0;
        sys_valid = 1'b0;
        lru_tags = '{6'd9, 6'd21, 6'd9, 6'd33, 6'd9, 6'd21};
        lru_expect = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            image[i] = $random(seed);
        end
        // Equal LRU bits after the sweep make way 0 the more recent
        for (int s = 0; s < `CACHE_SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_mru[s] = 1'b0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        assert (!sys_ready && !mem_valid)
            else stop_on_error("sys_ready or mem_valid high when reset was released");

        // First read lands while the invalidate sweep is still running
        read_word(make_addr(6'd3, 8'h21, 1'b1), seen_hit);
        read_word(make_addr(6'd3, 8'h21, 1'b1), seen_hit);
        assert (seen_hit) else stop_on_mismatch("repeated read of the same word missed");
        read_word(make_addr(6'd3, 8'h21, 1'b0), seen_hit);
        assert (seen_hit) else stop_on_mismatch("partner word of a filled line missed");

        // Order A, B, A, C in one set, then A and B again
        for (int i = 0; i < 6; i++) begin
            read_word(make_addr(lru_tags[i], 8'h5c, i[0]), seen_hit);
            assert (seen_hit == lru_expect[i])
                else stop_on_mismatch($sformatf("LRU step %0d saw hit %0b, expected %0b",
                                                i, seen_hit, lru_expect[i]));
        end

        // Small window of four tags over eight sets
        for (int i = 0; i < RANDOM_READS; i++) begin
            rnd = $random(seed);
            read_word(make_addr(tag_t'(rnd & 3), index_t'((rnd >> 2) & 7), rnd[5]), seen_hit);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== cache2way.f ====
+incdir+source
source/cache_pkg.sv
source/cache_way.sv
source/way_select.sv
source/cache_ctrl.sv
source/cache_top.sv
sim/cache_tb.sv

// ==== Makefile ====
# Verilator build and run of the two-way instruction cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= cache2way.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Test completed successfully

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
